/* filelist.f */
common/pe_cfg_pkg.sv
common/pe_ctrl_pkg.sv
ifmap_path/ifmap_path.sv
filter_path/filter_path.sv
logic/pe_controller.sv
logic/mac_pipeline.sv
logic/pe_top.sv
verif/pe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the processing element testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --top-module pe_tb \
    --Mdir "$build_dir" -o pe_sim -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/pe_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TB FAILED" "$log"; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TB PASSED" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* verif/pe_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module pe_tb;
    import pe_cfg_pkg::*;

    typedef struct packed {
        int stride;
        int fsize;
        int row_len;
        int prob;      // percent chance of popping a waiting sum
        int hold;      // cycles with data waiting before the first pop
        int max_data;  // every operand 8'hff
        int left;      // sums left in the fifo for the next clear to drop
    } case_t;

    localparam int N_CASES = 9;

    case_t cases [N_CASES] = '{
        '{1, 3, 16, 70, 0, 0, 0},
        '{1, 1, 16, 50, 0, 0, 0},
        '{1, 8, 16, 100, 0, 0, 3},  // last sums still queued when the next case clears
        '{2, 3, 15, 60, 0, 0, 0},
        '{3, 4, 16, 80, 0, 0, 0},
        '{3, 2, 8, 100, 0, 0, 0},
        '{1, 1, 16, 100, 40, 0, 0},  // fifo fills up, controller has to hold
        '{1, 8, 16, 100, 0, 1, 0},
        '{2, 8, 9, 100, 0, 0, 0}
    };

    logic                clk = 1'b0;
    logic                rst_n;
    logic                ld_cfg;
    pe_cfg_t             cfg_in;
    logic                filter_wen;
    logic [FILTER_W-1:0] filter_in;
    logic                ifmap_wen;
    logic [IFMAP_W-1:0]  ifmap_in;
    logic                clear;
    logic                start;
    logic                psum_ren;
    logic                av_data;
    logic                av_filter;
    logic                busy;
    logic                done;
    logic                psum_valid;
    logic [PSUM_W-1:0]   psum_out;

    logic [FILTER_W-1:0] filt [FILTER_ROWS];
    logic [IFMAP_W-1:0]  row [IFMAP_ROWS];
    logic [PSUM_W-1:0]   exp_q [$];
    int                  seed = 32'h8b32b0ec;
    int                  value_errs = 0;
    int                  flow_errs = 0;

    always #4 clk = ~clk;

    pe_top DUT (
        .clk, .rst_n, .ld_cfg, .cfg_in, .filter_wen, .filter_in, .ifmap_wen, .ifmap_in,
        .clear, .start, .psum_ren, .av_data, .av_filter, .busy, .done, .psum_valid,
        .psum_out
    );

    // --------------------------------------------------
    // reference model and helpers
    // --------------------------------------------------
    function automatic logic [PSUM_W-1:0] ref_psum(input int o, input int stride, input int fsize);
        logic [PSUM_W-1:0] acc;
        logic [15:0]       prod;
        logic [PTR_W-1:0]  idx;
        acc = '0;
        for (int k = 0; k < fsize; k++) begin
            idx  = PTR_W'(o * stride + k);
            prod = filt[TAP_W'(k)] * row[idx];
            acc  = acc + PSUM_W'(prod);  // wraps at 2^20
        end
        return acc;
    endfunction

    task automatic check_flag(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            value_errs++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic run_case(input int idx);
        case_t             c;
        int                n_out;
        int                got;
        int                valid_run;
        int                wait_cnt;
        bit                done_seen;
        bit                finished;
        bit                take;
        int unsigned       roll;
        logic [7:0]        val;
        logic [PSUM_W-1:0] exp_val;
        c     = cases[idx];
        n_out = (c.row_len - c.fsize) / c.stride + 1;

        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear  <= 1'b0;
        ld_cfg <= 1'b1;
        cfg_in <= '{stride: STRIDE_W'(c.stride), filter_size: FSIZE_W'(c.fsize),
                    row_len: LEN_W'(c.row_len)};
        @(posedge clk);
        ld_cfg <= 1'b0;
        @(negedge clk);
        check_flag("av_filter after clear", av_filter, 1'b0);
        check_flag("av_data after clear", av_data, 1'b0);
        check_flag("psum_valid after clear", psum_valid, 1'b0);

        for (int k = 0; k < c.fsize; k++) begin
            val = c.max_data != 0 ? 8'hff : 8'($random(seed));
            filt[TAP_W'(k)] = val;
            @(posedge clk);
            filter_wen <= 1'b1;
            filter_in  <= val;
            @(negedge clk);
            check_flag("av_filter while loading", av_filter, 1'b0);
        end
        @(posedge clk);
        filter_wen <= 1'b0;
        @(negedge clk);
        check_flag("av_filter after last tap", av_filter, 1'b1);

        for (int i = 0; i < c.row_len; i++) begin
            val = c.max_data != 0 ? 8'hff : 8'($random(seed));
            row[PTR_W'(i)] = val;
            @(posedge clk);
            ifmap_wen <= 1'b1;
            ifmap_in  <= val;
            @(negedge clk);
            check_flag("av_data while loading", av_data, 1'b0);
        end
        @(posedge clk);
        ifmap_wen <= 1'b0;
        wait_cnt = 0;
        @(negedge clk);
        while (!av_data && wait_cnt < 10) begin
            @(negedge clk);
            wait_cnt++;
        end
        check_flag("av_data after row drained", av_data, 1'b1);

        exp_q.delete();
        for (int o = 0; o < n_out; o++)
            exp_q.push_back(ref_psum(o, c.stride, c.fsize));

        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_flag("busy after start", busy, 1'b1);

        got       = 0;
        valid_run = 0;
        done_seen = 0;
        finished  = 0;
        while (!finished) begin
            @(negedge clk);
            if (psum_ren) begin  // this entry pops on the next edge
                if (exp_q.size() == 0) begin
                    flow_errs++;
                    $display("case %0d produced a partial sum beyond the expected %0d",
                             idx, n_out);
                end else begin
                    exp_val = exp_q.pop_front();
                    assert (psum_out === exp_val) else begin
                        value_errs++;
                        $display("FAIL %0t: case %0d psum %0d is %h, expected %h",
                                 $time, idx, got, psum_out, exp_val);
                    end
                end
                got++;
            end
            if (done) begin
                assert (!done_seen) else begin
                    flow_errs++;
                    $display("case %0d pulsed done more than once", idx);
                end
                check_flag("busy with done", busy, 1'b0);
                done_seen = 1;
            end
            if (psum_valid)
                valid_run++;
            roll     = $unsigned($random(seed)) % 100;
            take     = !psum_ren && psum_valid && valid_run > c.hold && roll < c.prob
                       && (c.left == 0 || got < n_out - c.left);
            finished = done_seen && !psum_ren
                       && (!psum_valid || (c.left != 0 && got == n_out - c.left));
            @(posedge clk);
            psum_ren <= take;
        end

        assert (got == n_out - c.left) else begin
            flow_errs++;
            $display("case %0d ended with %0d partial sums instead of %0d",
                     idx, got, n_out - c.left);
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        rst_n      = 1'b0;
        ld_cfg     = 1'b0;
        cfg_in     = '0;
        filter_wen = 1'b0;
        filter_in  = '0;
        ifmap_wen  = 1'b0;
        ifmap_in   = '0;
        clear      = 1'b0;
        start      = 1'b0;
        psum_ren   = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("av_data after reset", av_data, 1'b0);
        check_flag("av_filter after reset", av_filter, 1'b0);
        check_flag("busy after reset", busy, 1'b0);
        check_flag("done after reset", done, 1'b0);
        check_flag("psum_valid after reset", psum_valid, 1'b0);

        for (int i = 0; i < N_CASES; i++)
            run_case(i);

        $display("value errors: %0d, flow errors: %0d", value_errs, flow_errs);
        if (value_errs == 0 && flow_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog, sized from the table
    initial begin
        int budget;
        int n_out;
        budget = 20;
        for (int i = 0; i < N_CASES; i++) begin
            n_out  = (cases[i].row_len - cases[i].fsize) / cases[i].stride + 1;
            budget = budget + n_out * (cases[i].fsize + 8) + cases[i].row_len
                     + cases[i].fsize + cases[i].hold + 40;
        end
        budget = budget * 2;
        repeat (budget) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress", budget);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/pe_top.sv */
`default_nettype none
`timescale 1ns/100ps

module pe_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             ld_cfg,
    input  pe_cfg_pkg::pe_cfg_t              cfg_in,
    input  logic                             filter_wen,
    input  logic [pe_cfg_pkg::FILTER_W-1:0]  filter_in,
    input  logic                             ifmap_wen,
    input  logic [pe_cfg_pkg::IFMAP_W-1:0]   ifmap_in,
    input  logic                             clear,
    input  logic                             start,
    input  logic                             psum_ren,
    output logic                             av_data,
    output logic                             av_filter,
    output logic                             busy,
    output logic                             done,
    output logic                             psum_valid,
    output logic [pe_cfg_pkg::PSUM_W-1:0]    psum_out
);
    import pe_cfg_pkg::*;
    import pe_ctrl_pkg::*;

    pe_cfg_t             cfg;
    issue_cmd_t          cmd;
    mac_tag_t            tag;
    logic [IFMAP_W-1:0]  ifmap_rd;
    logic [FILTER_W-1:0] filter_rd;
    logic                psum_afull;

    pe_controller u_ctrl (
        .clk, .rst_n, .clear, .ld_cfg, .cfg_in, .start, .psum_afull,
        .cfg, .cmd, .busy, .done
    );

    ifmap_path u_ifmap (
        .clk, .rst_n, .clear, .ifmap_wen, .ifmap_in, .cfg, .cmd,
        .ifmap_rd, .av_data
    );

    filter_path u_filter (
        .clk, .rst_n, .clear, .filter_wen, .filter_in, .cfg, .cmd,
        .filter_rd, .tag, .av_filter
    );

    mac_pipeline u_mac (
        .clk, .rst_n, .clear, .ifmap_rd, .filter_rd, .tag, .psum_ren,
        .psum_out, .psum_valid, .psum_afull
    );

endmodule

`default_nettype wire

/* logic/mac_pipeline.sv */
`default_nettype none
`timescale 1ns/100ps

module mac_pipeline (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clear,
    input  logic [pe_cfg_pkg::IFMAP_W-1:0]   ifmap_rd,
    input  logic [pe_cfg_pkg::FILTER_W-1:0]  filter_rd,
    input  pe_cfg_pkg::mac_tag_t             tag,
    input  logic                             psum_ren,
    output logic [pe_cfg_pkg::PSUM_W-1:0]    psum_out,
    output logic                             psum_valid,
    output logic                             psum_afull
);
    import pe_cfg_pkg::*;

    logic [IFMAP_W+FILTER_W-1:0] prod_q;
    mac_tag_t                    s1_tag;
    logic [PSUM_W-1:0]           acc;
    logic [PSUM_W-1:0]           sum;
    logic [PSUM_W-1:0]           psum_mem [PSUM_FIFO_DEPTH];
    logic [PSQ_PTR_W-1:0]        wr_ptr;
    logic [PSQ_PTR_W-1:0]        rd_ptr;
    logic [PSQ_PTR_W:0]          psum_cnt;
    logic [1:0]                  in_flight;
    logic [PSQ_PTR_W+1:0]        committed;
    logic                        psum_wr;
    logic                        psum_push;
    logic                        psum_rd;
    logic                        psum_full;

    // --------------------------------------------------
    // stage one, multiply
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        prod_q <= ifmap_rd * filter_rd;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear)
            s1_tag <= '0;
        else
            s1_tag <= tag;
    end

    // --------------------------------------------------
    // stage two, accumulate and push
    // --------------------------------------------------
    assign sum = s1_tag.first_tap ? PSUM_W'(prod_q) : acc + PSUM_W'(prod_q);

    always_ff @(posedge clk) begin
        if (s1_tag.valid)
            acc <= sum;
    end

    assign psum_wr    = s1_tag.valid && s1_tag.last_tap;
    assign psum_full  = psum_cnt == (PSQ_PTR_W+1)'(PSUM_FIFO_DEPTH);
    assign psum_push  = psum_wr && !psum_full;
    assign psum_valid = psum_cnt != '0;
    assign psum_rd    = psum_ren && psum_valid;
    assign psum_out   = psum_mem[rd_ptr];  // show-ahead

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            psum_cnt <= '0;
        end else begin
            if (psum_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (psum_rd)
                rd_ptr <= rd_ptr + 1'b1;
            psum_cnt <= psum_cnt + (PSQ_PTR_W+1)'(psum_push) - (PSQ_PTR_W+1)'(psum_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (psum_push)
            psum_mem[wr_ptr] <= sum;
    end

    // sums still on their way count as taken slots
    assign in_flight  = 2'(tag.valid && tag.last_tap) + 2'(s1_tag.valid && s1_tag.last_tap);
    assign committed  = (PSQ_PTR_W+2)'(psum_cnt) + (PSQ_PTR_W+2)'(in_flight);
    assign psum_afull = committed >= (PSQ_PTR_W+2)'(PSUM_FIFO_DEPTH - 1);

    a_psum_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        psum_ren |-> psum_valid);

    // the controller's hold at output boundaries must keep a slot free
    a_psum_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        psum_wr |-> !psum_full);

endmodule

`default_nettype wire

/* logic/pe_controller.sv */
`default_nettype none
`timescale 1ns/100ps

module pe_controller (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear,
    input  logic                     ld_cfg,
    input  pe_cfg_pkg::pe_cfg_t      cfg_in,
    input  logic                     start,
    input  logic                     psum_afull,
    output pe_cfg_pkg::pe_cfg_t      cfg,
    output pe_ctrl_pkg::issue_cmd_t  cmd,
    output logic                     busy,
    output logic                     done
);
    import pe_cfg_pkg::*;
    import pe_ctrl_pkg::*;

    pe_state_e        state;
    logic [PTR_W-1:0] base;
    logic [TAP_W-1:0] tap;
    logic [1:0]       drain_cnt;
    logic             last_tap;
    logic             last_window;
    logic [LEN_W:0]   next_end;

    assign last_tap    = FSIZE_W'(tap) == (cfg.filter_size - FSIZE_W'(1));
    assign next_end    = (LEN_W+1)'(base) + (LEN_W+1)'(cfg.stride) + (LEN_W+1)'(cfg.filter_size);
    assign last_window = next_end > (LEN_W+1)'(cfg.row_len);  // next window would run off the row
    assign cmd         = '{put: state == ISSUE, window_base: base, tap: tap};
    assign busy        = state != IDLE;

    always_ff @(posedge clk) begin
        if (!rst_n)
            cfg <= '0;
        else if (ld_cfg)
            cfg <= cfg_in;
    end

    // --------------------------------------------------
    // issue fsm, one tap per cycle
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            state     <= IDLE;
            base      <= '0;
            tap       <= '0;
            drain_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        base  <= '0;
                        tap   <= '0;
                        state <= psum_afull ? HOLD : ISSUE;
                    end
                end
                ISSUE: begin
                    if (!last_tap) begin
                        tap <= tap + 1'b1;
                    end else begin
                        tap <= '0;
                        if (last_window) begin
                            state     <= DRAIN;
                            drain_cnt <= '0;
                        end else begin
                            base <= base + PTR_W'(cfg.stride);
                            if (psum_afull)
                                state <= HOLD;  // only checked between outputs
                        end
                    end
                end
                HOLD: begin
                    if (!psum_afull)
                        state <= ISSUE;
                end
                DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == 2'(DRAIN_LAT - 1)) begin
                        state <= IDLE;
                        done  <= 1'b1;  // last sum is in the fifo by now
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

`default_nettype wire

/* filter_path/filter_path.sv */
`default_nettype none
`timescale 1ns/100ps

module filter_path (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             clear,
    input  logic                             filter_wen,
    input  logic [pe_cfg_pkg::FILTER_W-1:0]  filter_in,
    input  pe_cfg_pkg::pe_cfg_t              cfg,
    input  pe_ctrl_pkg::issue_cmd_t          cmd,
    output logic [pe_cfg_pkg::FILTER_W-1:0]  filter_rd,
    output pe_cfg_pkg::mac_tag_t             tag,
    output logic                             av_filter
);
    import pe_cfg_pkg::*;

    logic [FILTER_W-1:0] spad [FILTER_ROWS];
    logic [FSIZE_W-1:0]  wr_cnt;
    logic                wr_ok;
    logic                at_last;

    assign wr_ok     = filter_wen && (wr_cnt < FSIZE_W'(FILTER_ROWS));
    assign at_last   = FSIZE_W'(cmd.tap) == (cfg.filter_size - FSIZE_W'(1));
    assign av_filter = (wr_cnt != '0) && (wr_cnt == cfg.filter_size);

    always_ff @(posedge clk) begin
        if (!rst_n || clear)
            wr_cnt <= '0;
        else if (wr_ok)
            wr_cnt <= wr_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (wr_ok)
            spad[wr_cnt[TAP_W-1:0]] <= filter_in;
        if (cmd.put)
            filter_rd <= spad[cmd.tap];
    end

    // tag follows the read by one cycle, same as the pad data
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            tag <= '0;
        end else begin
            tag <= '{valid:     cmd.put,
                     first_tap: cmd.tap == '0,
                     last_tap:  at_last};
        end
    end

    a_filter_room: assert property (@(posedge clk) disable iff (!rst_n)
        filter_wen |-> (wr_cnt < FSIZE_W'(FILTER_ROWS)));

endmodule

`default_nettype wire

/* ifmap_path/ifmap_path.sv */
`default_nettype none
`timescale 1ns/100ps

module ifmap_path (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            clear,
    input  logic                            ifmap_wen,
    input  logic [pe_cfg_pkg::IFMAP_W-1:0]  ifmap_in,
    input  pe_cfg_pkg::pe_cfg_t             cfg,
    input  pe_ctrl_pkg::issue_cmd_t         cmd,
    output logic [pe_cfg_pkg::IFMAP_W-1:0]  ifmap_rd,
    output logic                            av_data
);
    import pe_cfg_pkg::*;

    logic [IFMAP_W-1:0]   fifo_mem [IFMAP_FIFO_DEPTH];
    logic [IFQ_PTR_W-1:0] wr_ptr;
    logic [IFQ_PTR_W-1:0] rd_ptr;
    logic [IFQ_PTR_W:0]   fifo_cnt;
    logic [IFMAP_W-1:0]   spad [IFMAP_ROWS];
    logic [LEN_W-1:0]     fill;
    logic                 fifo_full;
    logic                 push;
    logic                 move;
    logic [PTR_W-1:0]     rd_addr;

    assign fifo_full = fifo_cnt == (IFQ_PTR_W+1)'(IFMAP_FIFO_DEPTH);
    assign push      = ifmap_wen && !fifo_full;
    assign move      = (fifo_cnt != '0) && (fill < LEN_W'(IFMAP_ROWS));  // fifo drains on its own
    assign rd_addr   = cmd.window_base + PTR_W'(cmd.tap);
    assign av_data   = (fill != '0) && (fill == cfg.row_len);

    // --------------------------------------------------
    // input fifo and fill counter
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
            fill     <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (move) begin
                rd_ptr <= rd_ptr + 1'b1;
                fill   <= fill + 1'b1;
            end
            fifo_cnt <= fifo_cnt + (IFQ_PTR_W+1)'(push) - (IFQ_PTR_W+1)'(move);
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            fifo_mem[wr_ptr] <= ifmap_in;
        if (move)
            spad[fill[PTR_W-1:0]] <= fifo_mem[rd_ptr];
        if (cmd.put)
            ifmap_rd <= spad[rd_addr];  // registered read, lines up with filter_rd
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        ifmap_wen |-> !fifo_full);

    // the controller only walks windows that the host has already loaded
    a_window_loaded: assert property (@(posedge clk) disable iff (!rst_n)
        cmd.put |-> (LEN_W'(rd_addr) < fill));

endmodule

`default_nettype wire

/* common/pe_ctrl_pkg.sv */
`default_nettype none

package pe_ctrl_pkg;

    // cycles from the last put until its sum sits in the psum fifo
    localparam int DRAIN_LAT = 3;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        HOLD,   // psum fifo nearly full, wait at an output boundary
        DRAIN
    } pe_state_e;

    typedef struct packed {
        logic                          put;
        logic [pe_cfg_pkg::PTR_W-1:0]  window_base;
        logic [pe_cfg_pkg::TAP_W-1:0]  tap;
    } issue_cmd_t;

endpackage

`default_nettype wire

/* common/pe_cfg_pkg.sv */
`default_nettype none

package pe_cfg_pkg;

    // --------------------------------------------------
    // datapath widths and depths
    // --------------------------------------------------
    localparam int IFMAP_W          = 8;
    localparam int FILTER_W         = 8;
    localparam int PSUM_W           = 20;  // accumulation wraps modulo 2^20
    localparam int IFMAP_ROWS       = 16;
    localparam int FILTER_ROWS      = 8;
    localparam int IFMAP_FIFO_DEPTH = 4;
    localparam int PSUM_FIFO_DEPTH  = 8;
    localparam int PTR_W            = 4;   // ifmap scratch pad address
    localparam int LEN_W            = 5;   // row length 1..16
    localparam int STRIDE_W         = 2;   // stride 1..3
    localparam int FSIZE_W          = 4;   // filter size 1..8
    localparam int TAP_W            = $clog2(FILTER_ROWS);
    localparam int IFQ_PTR_W        = $clog2(IFMAP_FIFO_DEPTH);
    localparam int PSQ_PTR_W        = $clog2(PSUM_FIFO_DEPTH);

    typedef struct packed {
        logic [STRIDE_W-1:0] stride;
        logic [FSIZE_W-1:0]  filter_size;
        logic [LEN_W-1:0]    row_len;
    } pe_cfg_t;

    typedef struct packed {
        logic valid;
        logic first_tap;  // load accumulator instead of add
        logic last_tap;   // push the sum to the psum fifo
    } mac_tag_t;

endpackage

`default_nettype wire
